// ==== flist.f ====
+incdir+source
source/fprf_pkg.sv
source/regfile_fp.sv
source/fp_operand_read.sv
source/wb_host_port.sv
source/fprf_top.sv
dv/fprf_tb.sv

// ==== Makefile ====
# Verilator build and run for the FP register file testbench.

SIM    := verilator
FLAGS  := --binary --timing --assert --timescale 1ns/1ps
TOP    := fprf_tb
FLIST  := flist.f
OBJDIR := obj_dir
PASS   := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS)'

clean:
	rm -rf $(OBJDIR)

// ==== dv/fprf_tb.sv ====
// Table-driven testbench for the FP register file block.
// Drives unit lanes, issues and the Wishbone host port, and checks against a shadow array.

`timescale 1ns/1ps

`include "fprf_consts.svh"

module fprf_tb
    import fprf_pkg::*;
();

    localparam int TIMEOUT = 50;                   // cycles per wait.
    localparam int ROUNDS  = 12;                   // random rounds.

    typedef enum logic [2:0] {
        ACT_LANE0, ACT_LANE1, ACT_HWR, ACT_WRITE3,
        ACT_ISSUE, ACT_BYPASS, ACT_HRD, ACT_STALL
    } act_e;

    typedef struct packed {
        act_e   act;
        phreg_t t1;                                // rs1, write tag or host tag.
        phreg_t t2;
        phreg_t t3;
        bus64_t data;
        logic   single;
        logic   use_rs3;
        logic   computed;                          // expected from shadow.
        bus64_t expv;
    } row_t;

    logic                      clk_i;
    logic                      rstn_i;
    logic   [`FP_WB_LANES-1:0] wb_we_i;
    phreg_t [`FP_WB_LANES-1:0] wb_tag_i;
    bus64_t [`FP_WB_LANES-1:0] wb_data_i;
    logic                      iss_valid_i;
    logic                      iss_single_i;
    logic                      iss_use_rs3_i;
    phreg_t                    iss_rs1_i;
    phreg_t                    iss_rs2_i;
    phreg_t                    iss_rs3_i;
    logic                      op_valid_o;
    bus64_t                    op1_o;
    bus64_t                    op2_o;
    bus64_t                    op3_o;
    logic                      cyc_i;
    logic                      stb_i;
    logic                      we_i;
    phreg_t                    adr_i;
    bus64_t                    dat_i;
    bus64_t                    dat_o;
    logic                      ack_o;

    bus64_t      shadow [`NUM_PHYS_FREGS];         // reference register file.
    row_t        rows [$];
    string       names [$];
    logic [31:0] lfsr_q;
    int          word_errors  = 0;
    int          valid_errors = 0;
    int          timeouts     = 0;

    fprf_top u_fprf_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                 // 4 ns period.
    end

    // **************************************************
    // random data and expected values
    // **************************************************

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic bus64_t rand_bits(input int n);
        bus64_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};             // one step per bit.
        end
        return v;
    endfunction

    // risc-v rule: a single without a full box reads as canonical nan.
    function automatic bus64_t expect_operand(input bus64_t raw, input logic single);
        fp_word_u w;
        w = raw;
        if (single && (w.sp.box != 32'hFFFF_FFFF)) begin
            return {32'hFFFF_FFFF, `CANON_NAN_S};
        end
        return raw;
    endfunction

    // **************************************************
    // compare tasks
    // **************************************************

    task automatic check_word(input string name, input bus64_t expected, input bus64_t actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            word_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            valid_errors++;
        end
    endtask

    // **************************************************
    // waits, each with its own timeout
    // **************************************************

    task automatic wait_ack(output logic ok);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!ack_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        ok = ack_o;
        if (!ok) begin
            $display("timeout: host port gave no ack within %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic wait_op(output int waited, output logic ok);
        waited = 0;
        @(negedge clk_i);
        while (!op_valid_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        ok = op_valid_o;
        if (!ok) begin
            $display("timeout: operand stage gave no valid within %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    // **************************************************
    // bus and lane actions
    // **************************************************

    task automatic release_bus();
        @(posedge clk_i);
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic start_host(input logic write, input phreg_t tag, input bus64_t data);
        cyc_i <= 1'b1;
        stb_i <= 1'b1;
        we_i  <= write;
        adr_i <= tag;
        dat_i <= data;
    endtask

    task automatic lane_write(input logic lane, input phreg_t tag, input bus64_t data);
        @(posedge clk_i);
        wb_we_i[lane]   <= 1'b1;
        wb_tag_i[lane]  <= tag;
        wb_data_i[lane] <= data;
        @(posedge clk_i);
        wb_we_i <= '0;
        shadow[tag] = data;
    endtask

    task automatic host_write(input phreg_t tag, input bus64_t data);
        logic ok;
        @(posedge clk_i);
        start_host(1'b1, tag, data);
        wait_ack(ok);
        shadow[tag] = data;
        release_bus();
    endtask

    // both unit lanes and the host lane in one cycle, distinct tags.
    task automatic write_all_lanes(input phreg_t t0, input phreg_t t1, input phreg_t th,
                                   input bus64_t data);
        logic ok;
        @(posedge clk_i);
        wb_we_i   <= 2'b11;
        wb_tag_i  <= {t1, t0};
        wb_data_i <= {{data[31:0], data[63:32]}, data};
        start_host(1'b1, th, ~data);
        @(posedge clk_i);
        wb_we_i <= '0;
        shadow[t0] = data;
        shadow[t1] = {data[31:0], data[63:32]};
        shadow[th] = ~data;
        wait_ack(ok);
        release_bus();
    endtask

    task automatic host_read(input string name, input phreg_t tag, input logic computed,
                             input bus64_t expv);
        logic ok;
        @(posedge clk_i);
        start_host(1'b0, tag, '0);
        wait_ack(ok);
        if (ok) begin
            check_word(name, computed ? shadow[tag] : expv, dat_o);
        end
        release_bus();
    endtask

    // **************************************************
    // issue actions
    // **************************************************

    // optional lane 1 write to rs1 in the issue cycle exercises the bypass.
    task automatic issue_check(input string name, input row_t r, input logic with_write);
        bus64_t e1;
        bus64_t e2;
        bus64_t e3;
        int     waited;
        logic   ok;
        @(posedge clk_i);
        iss_valid_i   <= 1'b1;
        iss_single_i  <= r.single;
        iss_use_rs3_i <= r.use_rs3;
        iss_rs1_i     <= r.t1;
        iss_rs2_i     <= r.t2;
        iss_rs3_i     <= r.t3;
        if (with_write) begin
            wb_we_i[1]   <= 1'b1;
            wb_tag_i[1]  <= r.t1;
            wb_data_i[1] <= r.data;
            shadow[r.t1] = r.data;
        end
        e1 = r.computed ? expect_operand(shadow[r.t1], r.single) : r.expv;
        e2 = expect_operand(shadow[r.t2], r.single);
        e3 = r.use_rs3 ? expect_operand(shadow[r.t3], r.single) : '0;
        @(posedge clk_i);
        iss_valid_i <= 1'b0;
        wb_we_i     <= '0;
        wait_op(waited, ok);
        if (ok) begin
            check_valid({name, " valid one cycle after issue"}, 1'b1, waited == 0);
            check_word({name, " op1"}, e1, op1_o);
            check_word({name, " op2"}, e2, op2_o);
            check_word({name, " op3"}, e3, op3_o);
        end
    endtask

    // host read held off by fma issues, then served by a two-source issue.
    task automatic stall_check(input string name, input phreg_t tag);
        logic ok;
        @(posedge clk_i);
        start_host(1'b0, tag, '0);
        iss_valid_i   <= 1'b1;
        iss_single_i  <= 1'b0;
        iss_use_rs3_i <= 1'b1;
        iss_rs1_i     <= 6'd0;
        iss_rs2_i     <= 6'd1;
        for (int k = 0; k < 4; k++) begin
            iss_rs3_i <= phreg_t'(k + 3);
            @(negedge clk_i);
            check_valid({name, " no ack while rs3 busy"}, 1'b0, ack_o);
            @(posedge clk_i);
        end
        iss_use_rs3_i <= 1'b0;                     // port 3 now free.
        @(posedge clk_i);
        iss_valid_i <= 1'b0;
        wait_ack(ok);
        if (ok) begin
            check_word(name, shadow[tag], dat_o);
        end
        release_bus();
    endtask

    // **************************************************
    // stimulus table
    // **************************************************

    function automatic void add_row(input string name, input act_e act, input phreg_t t1,
                                    input phreg_t t2, input phreg_t t3, input bus64_t data,
                                    input logic single, input logic use_rs3,
                                    input logic computed, input bus64_t expv);
        row_t r;
        r = '{act, t1, t2, t3, data, single, use_rs3, computed, expv};
        rows.push_back(r);
        names.push_back(name);
    endfunction

    function automatic void build_table();
        phreg_t t;
        bus64_t d;
        // reset values.
        add_row("reset r0", ACT_HRD, 6'd0, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b0, 64'd0);
        add_row("reset r1", ACT_HRD, 6'd1, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b0, 64'd1);
        add_row("reset r2", ACT_HRD, 6'd2, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b0, 64'd2);
        add_row("reset r5", ACT_HRD, 6'd5, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b0, 64'd0);
        // stored writes, all lanes at once and one at a time.
        add_row("write3", ACT_WRITE3, 6'd10, 6'd11, 6'd12, 64'h4009_21FB_5444_2D18,
                1'b0, 1'b0, 1'b1, '0);
        add_row("host write", ACT_HWR, 6'd40, 6'd0, 6'd0, 64'hC0FF_EE00_1234_ABCD,
                1'b0, 1'b0, 1'b1, '0);
        add_row("fma read", ACT_ISSUE, 6'd10, 6'd11, 6'd12, '0, 1'b0, 1'b1, 1'b1, '0);
        add_row("read r11", ACT_HRD, 6'd11, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b1, '0);
        add_row("read r12", ACT_HRD, 6'd12, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b1, '0);
        add_row("read r40", ACT_HRD, 6'd40, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b1, '0);
        // same-cycle bypass.
        add_row("bypass", ACT_BYPASS, 6'd20, 6'd10, 6'd0, 64'hDEAD_BEEF_0BAD_F00D,
                1'b0, 1'b0, 1'b0, 64'hDEAD_BEEF_0BAD_F00D);
        // nan-boxing.
        add_row("unboxed", ACT_LANE0, 6'd30, 6'd0, 6'd0, 64'h1234_5678_3F80_0000,
                1'b0, 1'b0, 1'b1, '0);
        add_row("boxed", ACT_LANE1, 6'd31, 6'd0, 6'd0, 64'hFFFF_FFFF_3F80_0000,
                1'b0, 1'b0, 1'b1, '0);
        add_row("single bad box", ACT_ISSUE, 6'd30, 6'd31, 6'd0, '0, 1'b1, 1'b0, 1'b0,
                64'hFFFF_FFFF_7FC0_0000);
        add_row("single good box", ACT_ISSUE, 6'd31, 6'd30, 6'd12, '0, 1'b1, 1'b1, 1'b0,
                64'hFFFF_FFFF_3F80_0000);
        add_row("double raw", ACT_ISSUE, 6'd30, 6'd31, 6'd0, '0, 1'b0, 1'b0, 1'b0,
                64'h1234_5678_3F80_0000);
        // host read behind rs3 users.
        add_row("stall", ACT_STALL, 6'd12, 6'd0, 6'd0, '0, 1'b0, 1'b0, 1'b1, '0);
        // random rounds, lane tags kept apart by xor.
        for (int k = 0; k < ROUNDS; k++) begin
            t = phreg_t'(rand_bits(6));
            d = rand_bits(64);
            if (rand_bits(1) != '0) begin
                d[63:32] = '1;                     // well boxed single.
            end
            add_row($sformatf("rnd%0d write", k), ACT_WRITE3, t, t ^ 6'd1, t ^ 6'd2, d,
                    1'b0, 1'b0, 1'b1, '0);
            add_row($sformatf("rnd%0d issue", k), ACT_ISSUE, phreg_t'(rand_bits(6)),
                    t ^ 6'd1, t, '0, rand_bits(1) != '0, rand_bits(1) != '0, 1'b1, '0);
            add_row($sformatf("rnd%0d read", k), ACT_HRD, t ^ 6'd2, 6'd0, 6'd0, '0,
                    1'b0, 1'b0, 1'b1, '0);
        end
    endfunction

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        row_t r;
        lfsr_q        = 32'h2104_d0d8;
        rstn_i        = 1'b0;
        wb_we_i       = '0;
        wb_tag_i      = '0;
        wb_data_i     = '0;
        iss_valid_i   = 1'b0;
        iss_single_i  = 1'b0;
        iss_use_rs3_i = 1'b0;
        iss_rs1_i     = '0;
        iss_rs2_i     = '0;
        iss_rs3_i     = '0;
        cyc_i         = 1'b0;
        stb_i         = 1'b0;
        we_i          = 1'b0;
        adr_i         = '0;
        dat_i         = '0;
        for (int i = 0; i < `NUM_PHYS_FREGS; i++) begin
            shadow[i] = (i < 3) ? bus64_t'(i) : '0;
        end
        build_table();
        repeat (16) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            case (r.act)
                ACT_LANE0:  lane_write(1'b0, r.t1, r.data);
                ACT_LANE1:  lane_write(1'b1, r.t1, r.data);
                ACT_HWR:    host_write(r.t1, r.data);
                ACT_WRITE3: write_all_lanes(r.t1, r.t2, r.t3, r.data);
                ACT_ISSUE:  issue_check(names[i], r, 1'b0);
                ACT_BYPASS: issue_check(names[i], r, 1'b1);
                ACT_HRD:    host_read(names[i], r.t1, r.computed, r.expv);
                ACT_STALL:  stall_check(names[i], r.t1);
                default:    ;
            endcase
        end
        repeat (4) @(posedge clk_i);
        $display("errors: %0d word, %0d valid, %0d timeout", word_errors, valid_errors,
                 timeouts);
        if (word_errors + valid_errors + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== source/fprf_top.sv ====
// Top of the FP register file block: register file, operand-read stage and host port.
// Unit writeback lanes come from outside; the host port adds the last write lane.

`timescale 1ns/1ps

`include "fprf_consts.svh"

module fprf_top
    import fprf_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // unit writeback lanes.
    input  logic   [`FP_WB_LANES-1:0]   wb_we_i,
    input  phreg_t [`FP_WB_LANES-1:0]   wb_tag_i,
    input  bus64_t [`FP_WB_LANES-1:0]   wb_data_i,
    // issue.
    input  logic                        iss_valid_i,
    input  logic                        iss_single_i,
    input  logic                        iss_use_rs3_i,
    input  phreg_t                      iss_rs1_i,
    input  phreg_t                      iss_rs2_i,
    input  phreg_t                      iss_rs3_i,
    // operands.
    output logic                        op_valid_o,
    output bus64_t                      op1_o,
    output bus64_t                      op2_o,
    output bus64_t                      op3_o,
    // wishbone host.
    input  logic                        cyc_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  phreg_t                      adr_i,
    input  bus64_t                      dat_i,
    output bus64_t                      dat_o,
    output logic                        ack_o
);

    logic   hw_we;                                 // host lane enable.
    phreg_t hw_tag;
    bus64_t hw_data;
    logic   host_rd_req;                           // port 3 borrow.
    phreg_t host_rd_tag;
    logic   host_rd_gnt;
    bus64_t host_rd_data;
    phreg_t rd_addr1, rd_addr2, rd_addr3;
    bus64_t rd_data1, rd_data2, rd_data3;

    regfile_fp u_regfile_fp (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_enable_i ({hw_we, wb_we_i}),        // host on top lane.
        .write_addr_i   ({hw_tag, wb_tag_i}),
        .write_data_i   ({hw_data, wb_data_i}),
        .read_addr1_i   (rd_addr1),
        .read_addr2_i   (rd_addr2),
        .read_addr3_i   (rd_addr3),
        .read_data1_o   (rd_data1),
        .read_data2_o   (rd_data2),
        .read_data3_o   (rd_data3)
    );

    fp_operand_read u_fp_operand_read (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .iss_valid_i (iss_valid_i), .iss_single_i (iss_single_i),
        .iss_use_rs3_i (iss_use_rs3_i),
        .iss_rs1_i (iss_rs1_i), .iss_rs2_i (iss_rs2_i), .iss_rs3_i (iss_rs3_i),
        .rd_addr1_o (rd_addr1), .rd_addr2_o (rd_addr2), .rd_addr3_o (rd_addr3),
        .rd_data1_i (rd_data1), .rd_data2_i (rd_data2), .rd_data3_i (rd_data3),
        .host_rd_req_i (host_rd_req), .host_rd_tag_i (host_rd_tag),
        .host_rd_gnt_o (host_rd_gnt), .host_rd_data_o (host_rd_data),
        .op_valid_o (op_valid_o), .op1_o (op1_o), .op2_o (op2_o), .op3_o (op3_o)
    );

    wb_host_port u_wb_host_port (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i), .dat_i (dat_i),
        .dat_o (dat_o), .ack_o (ack_o),
        .hw_we_o (hw_we), .hw_tag_o (hw_tag), .hw_data_o (hw_data),
        .host_rd_req_o (host_rd_req), .host_rd_tag_o (host_rd_tag),
        .host_rd_gnt_i (host_rd_gnt), .host_rd_data_i (host_rd_data)
    );

endmodule

// ==== source/wb_host_port.sv ====
// Wishbone classic slave for a debug host: 64-bit word access to physical FP registers.
// Writes go out on the host write lane, reads wait for a grant on the shared read port.

`timescale 1ns/1ps

module wb_host_port
    import fprf_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    // wishbone slave.
    input  logic   cyc_i,
    input  logic   stb_i,
    input  logic   we_i,
    input  phreg_t adr_i,
    input  bus64_t dat_i,
    output bus64_t dat_o,
    output logic   ack_o,
    // host write lane.
    output logic   hw_we_o,
    output phreg_t hw_tag_o,
    output bus64_t hw_data_o,
    // shared read port request.
    output logic   host_rd_req_o,
    output phreg_t host_rd_tag_o,
    input  logic   host_rd_gnt_i,
    input  bus64_t host_rd_data_i
);

    logic req_live;                                // strobe not yet acked.
    logic rd_fire;                                 // read granted this cycle.

    // **************************************************
    // bus decode
    // **************************************************

    // ack cycle still has stb high, so mask it off.
    assign req_live = cyc_i && stb_i && !ack_o;

    // write goes straight to the lane in the first cycle.
    assign hw_we_o   = req_live && we_i;
    assign hw_tag_o  = adr_i;
    assign hw_data_o = dat_i;

    // read request held until the port is free.
    assign host_rd_req_o = req_live && !we_i;
    assign host_rd_tag_o = adr_i;
    assign rd_fire       = host_rd_req_o && host_rd_gnt_i;

    // **************************************************
    // ack and read data
    // **************************************************

    // write ack lands one cycle after the lane write and read ack trails the grant.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= hw_we_o || rd_fire;
        end
    end

    // data held until the next granted read.
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            dat_o <= host_rd_data_i;
        end
    end

    // the master keeps its strobe up until the ack arrives.
    a_ack_in_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ack_o |-> (cyc_i && stb_i)
    ) else $error("ack_o raised after the master dropped its strobe");

endmodule

// ==== source/fp_operand_read.sv ====
// Operand-read stage: drives the three register file read ports for an issued instruction.
// Single-format operands are NaN-boxed checked; port 3 is lent to the host when rs3 is idle.

`timescale 1ns/1ps

`include "fprf_consts.svh"

module fp_operand_read
    import fprf_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    // issue side.
    input  logic   iss_valid_i,
    input  logic   iss_single_i,
    input  logic   iss_use_rs3_i,
    input  phreg_t iss_rs1_i,
    input  phreg_t iss_rs2_i,
    input  phreg_t iss_rs3_i,
    // register file read ports.
    output phreg_t rd_addr1_o,
    output phreg_t rd_addr2_o,
    output phreg_t rd_addr3_o,
    input  bus64_t rd_data1_i,
    input  bus64_t rd_data2_i,
    input  bus64_t rd_data3_i,
    // host borrow of port 3.
    input  logic   host_rd_req_i,
    input  phreg_t host_rd_tag_i,
    output logic   host_rd_gnt_o,
    output bus64_t host_rd_data_o,
    // registered operands.
    output logic   op_valid_o,
    output bus64_t op1_o,
    output bus64_t op2_o,
    output bus64_t op3_o
);

    logic rs3_busy;                                // port 3 owned by the issue.

    // replace a badly boxed single with the canonical nan.
    function automatic bus64_t nan_box(input bus64_t raw, input logic single);
        fp_word_u w;
        w = raw;
        if (single && (w.sp.box != '1)) begin
            w.sp.box                       = '1;
            {w.sp.sign, w.sp.exp, w.sp.mant} = `CANON_NAN_S;
        end
        return bus64_t'(w);
    endfunction

    // **************************************************
    // read port steering
    // **************************************************

    assign rs3_busy       = iss_valid_i && iss_use_rs3_i;
    assign rd_addr1_o     = iss_rs1_i;
    assign rd_addr2_o     = iss_rs2_i;
    assign rd_addr3_o     = rs3_busy ? iss_rs3_i : host_rd_tag_i;
    assign host_rd_gnt_o  = host_rd_req_i && !rs3_busy;   // host waits behind fma.
    assign host_rd_data_o = rd_data3_i;                   // raw word without boxing.

    // **************************************************
    // operand registers
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= iss_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            op1_o <= nan_box(rd_data1_i, iss_single_i);
            op2_o <= nan_box(rd_data2_i, iss_single_i);
            op3_o <= iss_use_rs3_i ? nan_box(rd_data3_i, iss_single_i) : '0;
        end
    end

    // a refused host read stays pending on the same tag.
    a_host_req_held: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (host_rd_req_i && !host_rd_gnt_o) |=> (host_rd_req_i && $stable(host_rd_tag_i))
    ) else $error("host read request dropped or changed before grant");

endmodule

// ==== source/regfile_fp.sv ====
// Physical FP register file: unit writeback lanes plus one host lane, three read ports.
// Reads are combinational and return same-cycle write data through the bypass.
// Lane FP_WB_LANES is the host lane.

`timescale 1ns/1ps

`include "fprf_consts.svh"

module regfile_fp
    import fprf_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // write lanes, units first and host last.
    input  logic   [`FP_WB_LANES:0]    write_enable_i,
    input  phreg_t [`FP_WB_LANES:0]    write_addr_i,
    input  bus64_t [`FP_WB_LANES:0]    write_data_i,
    // read addresses.
    input  phreg_t                     read_addr1_i,
    input  phreg_t                     read_addr2_i,
    input  phreg_t                     read_addr3_i,
    // read data.
    output bus64_t                     read_data1_o,
    output bus64_t                     read_data2_o,
    output bus64_t                     read_data3_o
);

    localparam int NUM_LANES = `FP_WB_LANES + 1;   // units plus host.

    bus64_t regs [`NUM_PHYS_FREGS];                // storage array.
    logic   lane_clash;                            // two lanes on one tag.

    // **************************************************
    // read with same-cycle bypass
    // **************************************************

    // stored word unless an enabled lane is writing this tag now.
    function automatic bus64_t read_port(input phreg_t addr);
        bus64_t data;
        data = regs[addr];
        for (int l = 0; l < NUM_LANES; l++) begin
            if (write_enable_i[l] && (write_addr_i[l] == addr)) begin
                data = write_data_i[l];            // newest value wins.
            end
        end
        return data;
    endfunction

    always_comb begin
        read_data1_o = read_port(read_addr1_i);
        read_data2_o = read_port(read_addr2_i);
        read_data3_o = read_port(read_addr3_i);    // shared with the host.
    end

    // **************************************************
    // write lanes
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            // first three registers come up holding their index.
            for (int i = 0; i < `NUM_PHYS_FREGS; i++) begin
                regs[i] <= (i < 3) ? bus64_t'(i) : '0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (write_enable_i[l]) begin
                    regs[write_addr_i[l]] <= write_data_i[l];
                end
            end
        end
    end

    // **************************************************
    // lane tag check
    // **************************************************

    // pairwise compare of every enabled lane.
    always_comb begin
        lane_clash = 1'b0;
        for (int a = 0; a < NUM_LANES; a++) begin
            for (int b = a + 1; b < NUM_LANES; b++) begin
                if (write_enable_i[a] && write_enable_i[b] &&
                    (write_addr_i[a] == write_addr_i[b])) begin
                    lane_clash = 1'b1;
                end
            end
        end
    end

    // rename and the host port must never target one tag together.
    a_no_lane_clash: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !lane_clash
    ) else $error("two write lanes hit the same physical tag");

endmodule

// ==== source/fprf_pkg.sv ====
// Shared types for the FP register file, the operand-read stage and the host port.
// Modules pull these in with a wildcard import in their header.

package fprf_pkg;

    `include "fprf_consts.svh"

    typedef logic [`PHREG_W-1:0] phreg_t;   // physical register tag.
    typedef logic [63:0]         bus64_t;   // raw register word.

    // double precision layout, ieee 754 binary64.
    typedef struct packed {
        logic        sign;
        logic [10:0] exp;
        logic [51:0] mant;
    } fp_double_t;

    // single precision held in a 64-bit register.
    // upper half must be all ones for a valid box.
    typedef struct packed {
        logic [31:0] box;                   // nan-box, all ones if valid.
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp_single_boxed_t;

    // one register word, two decodes.
    typedef union packed {
        fp_double_t       dp;               // double view.
        fp_single_boxed_t sp;               // boxed single view.
    } fp_word_u;

endpackage

// ==== source/fprf_consts.svh ====
// Sizing constants for the floating-point physical register file.
// Include this wherever tag widths, lane counts or the canonical NaN are needed.

`ifndef FPRF_CONSTS_SVH
`define FPRF_CONSTS_SVH

// **************************************************
// register file geometry
// **************************************************

`define NUM_PHYS_FREGS 64           // physical fp registers.
`define PHREG_W        6            // bits in a physical tag.

// **************************************************
// write lanes
// **************************************************

`define FP_WB_LANES    2            // unit writeback lanes, host lane is extra.

// **************************************************
// floating-point encodings
// **************************************************

`define CANON_NAN_S    32'h7FC0_0000 // canonical quiet nan, single.

`endif
